/* flist.f */
design/rf_pkg.sv
design/rf_reset_sync.sv
design/rf_array_4x28.sv
design/rf_pg_4x27.sv
design/rf_pg_ctrl.sv
design/rf_fifo_wr.sv
design/rf_fifo_rd.sv
design/rf_fifo_top.sv
dv/rf_fifo_chk.sv
dv/rf_fifo_tb.sv

/* Makefile */
# Verilator build and run for the register file FIFO testbench

SIM  := obj_dir/Vrf_fifo_tb
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module rf_fifo_tb \
		-f flist.f -o Vrf_fifo_tb

# The log decides pass or fail
run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/rf_fifo_tb.sv */
//--------------------------------------------------------------------------
// Directed testbench for the dual-clock register file FIFO
// Clocks, reset, reference queue, read monitor and one task per test
//--------------------------------------------------------------------------

module rf_fifo_tb;
    import rf_pkg::*;

    localparam int SYNC = 2;

    logic     wclk;
    logic     rclk;
    logic     arst_n;
    logic     wr_en;
    rf_data_t wr_data;
    logic     rd_en;
    logic     sleep_req;
    logic     full;
    logic     empty;
    logic     rd_valid;
    rf_data_t rd_data;
    logic     pg_ready;

    // Every word the DUT has taken, in order, and how far the reads got
    rf_data_t ref_q[$];
    int       rd_idx = 0;
    int       mon_err_cnt = 0;
    int       err_cnt = 0;
    int       err_start = 0;
    int       test_cnt = 0;
    int       test_fail_cnt = 0;
    string    cur_test = "init";

    rf_fifo_top #(.SYNC_STAGES(SYNC)) i_rf_fifo_top (.*);

    bind rf_fifo_top rf_fifo_chk i_rf_fifo_chk (
         .wclk         (wclk)
        ,.rclk         (rclk)
        ,.wrst_n       (wrst_n)
        ,.rrst_n       (rrst_n)
        ,.we           (we)
        ,.full         (full)
        ,.re           (re)
        ,.empty        (empty)
        ,.rd_valid     (rd_valid)
        ,.pgcb_isol_en (pgcb_isol_en)
        ,.pwr_enable_b (pwr_enable_b)
        ,.pg_ready     (pg_ready)
        ,.pg_state     (i_rf_pg_ctrl.state_q)
    );

    initial begin
        wclk = 1'b0;
        forever #5 wclk = ~wclk;
    end

    // Read clock runs unrelated to the write clock
    initial begin
        rclk = 1'b0;
        forever #7 rclk = ~rclk;
    end

    //----------------------------------------------------------------------
    // Read monitor

    // Each rd_valid pulse must carry the oldest word not yet returned
    always @(negedge rclk) begin
        if (arst_n && rd_valid) begin
            assert (rd_idx < ref_q.size()) else begin
                $display("[ERROR] %s: rd_valid with no word outstanding", cur_test);
                mon_err_cnt++;
            end
            if (rd_idx < ref_q.size()) begin
                assert (rd_data == ref_q[rd_idx]) else begin
                    $display("[FAIL] %s: rd_data expected %h actual %h",
                             cur_test, ref_q[rd_idx], rd_data);
                    mon_err_cnt++;
                end
                rd_idx++;
            end
        end
    end

    //----------------------------------------------------------------------
    // Helpers

    task automatic check_eq(string what, int exp, int act);
        assert (exp == act) else begin
            $display("[FAIL] %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_ok(bit ok, string what);
        assert (ok) else begin
            $display("[ERROR] %s: %s", cur_test, what);
            err_cnt++;
        end
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        err_start = err_cnt + mon_err_cnt;
    endtask

    task automatic end_test;
        int n;
        n = err_cnt + mon_err_cnt - err_start;
        test_cnt++;
        if (n == 0) begin
            $display("test %s: passed", cur_test);
        end else begin
            test_fail_cnt++;
            $display("test %s: %0d errors", cur_test, n);
        end
    endtask

    // Gives pointers and pg_ready time to cross into wclk
    task automatic settle;
        repeat (SYNC + 2) @(negedge wclk);
    endtask

    task automatic wait_ready(bit level);
        int n;
        n = 0;
        while (pg_ready !== level && n < 200) begin
            @(negedge rclk);
            n++;
        end
        check_ok(pg_ready === level, $sformatf("pg_ready never reached %b", level));
    endtask

    task automatic wait_empty(bit level);
        int n;
        n = 0;
        while (empty !== level && n < 200) begin
            @(negedge rclk);
            n++;
        end
        check_ok(empty === level, $sformatf("empty never reached %b", level));
    endtask

    // Sampled on the rising edge so the monitor has settled
    task automatic wait_drained;
        int n;
        n = 0;
        while (rd_idx < ref_q.size() && n < 200) begin
            @(posedge rclk);
            n++;
        end
        check_ok(rd_idx == ref_q.size(), "words still outstanding after timeout");
    endtask

    // The model keeps a word only if the DUT is able to take it
    task automatic write_words(int n);
        repeat (n) begin
            @(negedge wclk);
            wr_en   = 1'b1;
            wr_data = rf_data_t'($urandom);
            if (!full && pg_ready) begin
                ref_q.push_back(wr_data);
            end
        end
        @(negedge wclk);
        wr_en = 1'b0;
    endtask

    // Requests exactly n reads, each only when empty is low
    task automatic read_words(int n);
        int got;
        int t;
        got = 0;
        t   = 0;
        while (got < n && t < 200) begin
            @(negedge rclk);
            rd_en = !empty;
            if (!empty) begin
                got++;
            end
            t++;
        end
        @(negedge rclk);
        rd_en = 1'b0;
        check_ok(got == n, $sformatf("only %0d of %0d reads issued", got, n));
    endtask

    //----------------------------------------------------------------------
    // Tests

    task automatic test_reset;
        start_test("reset");
        check_eq("empty", 1, int'(empty));
        check_eq("full", 0, int'(full));
        check_eq("rd_valid", 0, int'(rd_valid));
        check_eq("pg_ready", 0, int'(pg_ready));
        wait_ready(1'b1);
        end_test();
    endtask

    task automatic test_single;
        start_test("single_word");
        settle();
        write_words(1);
        read_words(1);
        check_eq("rd_valid", 1, int'(rd_valid));
        @(negedge rclk);
        check_eq("rd_valid", 0, int'(rd_valid));
        wait_drained();
        wait_empty(1'b1);
        end_test();
    endtask

    task automatic test_fill;
        start_test("fill_to_full");
        settle();
        write_words(RF_DEPTH);
        check_eq("full", 1, int'(full));
        // A fifth word is offered while full
        write_words(1);
        check_eq("full", 1, int'(full));
        check_eq("queued", RF_DEPTH, ref_q.size() - rd_idx);
        read_words(RF_DEPTH);
        wait_drained();
        wait_empty(1'b1);
        repeat (6) @(negedge rclk);
        check_eq("empty", 1, int'(empty));
        end_test();
    endtask

    task automatic test_random;
        start_test("random_traffic");
        settle();
        fork
            begin
                repeat (200) begin
                    @(negedge wclk);
                    wr_en   = 1'($urandom);
                    wr_data = rf_data_t'($urandom);
                    if (wr_en && !full && pg_ready) begin
                        ref_q.push_back(wr_data);
                    end
                end
                @(negedge wclk);
                wr_en = 1'b0;
            end
            begin
                repeat (200) begin
                    @(negedge rclk);
                    rd_en = 1'($urandom);
                end
                @(negedge rclk);
                rd_en = 1'b0;
            end
        join
        @(posedge rclk);
        read_words(ref_q.size() - rd_idx);
        wait_drained();
        wait_empty(1'b1);
        end_test();
    endtask

    task automatic test_sleep_hold;
        start_test("sleep_hold");
        settle();
        write_words(2);
        wait_empty(1'b0);
        @(negedge rclk);
        sleep_req = 1'b1;
        // Stored data keeps the array powered
        repeat (20) begin
            @(negedge rclk);
            check_eq("pg_ready", 1, int'(pg_ready));
        end
        read_words(2);
        wait_drained();
        wait_ready(1'b0);
        settle();
        write_words(6);
        check_eq("full", 0, int'(full));
        repeat (10) begin
            @(negedge rclk);
            check_eq("empty", 1, int'(empty));
        end
        end_test();
    endtask

    task automatic test_wake;
        start_test("wake_up");
        @(negedge rclk);
        sleep_req = 1'b0;
        wait_ready(1'b1);
        check_eq("empty", 1, int'(empty));
        check_eq("full", 0, int'(full));
        settle();
        write_words(3);
        read_words(3);
        wait_drained();
        wait_empty(1'b1);
        end_test();
    endtask

    //----------------------------------------------------------------------
    // Main sequence

    initial begin
        void'($urandom(32'he7ac801f));
        arst_n    = 1'b0;
        wr_en     = 1'b0;
        wr_data   = '0;
        rd_en     = 1'b0;
        sleep_req = 1'b0;
        repeat (16) @(negedge wclk);
        arst_n = 1'b1;
        test_reset();
        test_single();
        test_fill();
        test_random();
        test_sleep_hold();
        test_wake();
        $display("summary: %0d tests, %0d failed, %0d check errors, assertions fired %b",
                 test_cnt, test_fail_cnt, err_cnt + mon_err_cnt,
                 i_rf_fifo_top.i_rf_fifo_chk.fired);
        if (err_cnt + mon_err_cnt == 0 && !i_rf_fifo_top.i_rf_fifo_chk.fired) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : rf_fifo_tb

/* dv/rf_fifo_chk.sv */
//--------------------------------------------------------------------------
// Concurrent assertions for the FIFO top level
// Flow flags, read latency, isolation order and sequencer ready
//--------------------------------------------------------------------------

module rf_fifo_chk
    import rf_pkg::*;
(
     input logic      wclk
    ,input logic      rclk
    ,input logic      wrst_n
    ,input logic      rrst_n
    ,input logic      we
    ,input logic      full
    ,input logic      re
    ,input logic      empty
    ,input logic      rd_valid
    ,input logic      pgcb_isol_en
    ,input logic      pwr_enable_b
    ,input logic      pg_ready
    ,input pg_state_e pg_state
);

    // Sticky flags, one per assertion, gathered into fired
    logic bad_write = 1'b0;
    logic bad_read  = 1'b0;
    logic bad_valid = 1'b0;
    logic bad_iso   = 1'b0;
    logic bad_ready = 1'b0;
    logic fired;

    assign fired = bad_write | bad_read | bad_valid | bad_iso | bad_ready;

    // No write reaches the array while full
    a_write_full: assert property (@(posedge wclk) disable iff (!wrst_n)
        we |-> !full)
    else begin
        $error("write strobe while full");
        bad_write = 1'b1;
    end

    // No read reaches the array while empty
    a_read_empty: assert property (@(posedge rclk) disable iff (!rrst_n)
        re |-> !empty)
    else begin
        $error("read strobe while empty");
        bad_read = 1'b1;
    end

    // rd_valid is the read strobe delayed by exactly one rclk cycle
    a_valid_delay: assert property (@(posedge rclk) disable iff (!rrst_n)
        rd_valid == $past(re))
    else begin
        $error("rd_valid not one cycle after the read strobe");
        bad_valid = 1'b1;
    end

    // Power may only be off behind isolation
    a_iso_power: assert property (@(posedge rclk) disable iff (!rrst_n)
        pwr_enable_b |-> pgcb_isol_en)
    else begin
        $error("power enable high without isolation");
        bad_iso = 1'b1;
    end

    a_ready_on: assert property (@(posedge rclk) disable iff (!rrst_n)
        pg_ready |-> (pg_state == pg_on))
    else begin
        $error("pg_ready high outside pg_on");
        bad_ready = 1'b1;
    end

endmodule : rf_fifo_chk

/* design/rf_fifo_top.sv */
//--------------------------------------------------------------------------
// Dual-clock FIFO top level
// Write side, read side, power sequencer and power-gated register file
//--------------------------------------------------------------------------

module rf_fifo_top
    import rf_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
     input  logic     wclk
    ,input  logic     rclk
    ,input  logic     arst_n

    ,input  logic     wr_en
    ,input  rf_data_t wr_data
    ,output logic     full

    ,input  logic     rd_en
    ,input  logic     sleep_req
    ,output logic     empty
    ,output logic     rd_valid
    ,output rf_data_t rd_data
    ,output logic     pg_ready
);

    // Per-domain resets
    logic     wrst_n;
    logic     rrst_n;

    // Register file ports
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    rf_data_t rdata;

    // Pointers crossing between the domains
    rf_ptr_t  wr_ptr_gray;
    rf_ptr_t  rd_ptr_gray;

    // Power controls
    logic     pgcb_isol_en;
    logic     pwr_enable_b;
    logic     pwr_enable_b_out;

    //----------------------------------------------------------------------
    // Reset synchronizers

    rf_reset_sync i_wrst_sync (
         .clk        (wclk)
        ,.arst_n     (arst_n)
        ,.rst_n_sync (wrst_n)
    );

    rf_reset_sync i_rrst_sync (
         .clk        (rclk)
        ,.arst_n     (arst_n)
        ,.rst_n_sync (rrst_n)
    );

    //----------------------------------------------------------------------
    // FIFO control

    rf_fifo_wr #(.SYNC_STAGES(SYNC_STAGES)) i_rf_fifo_wr (
         .wclk        (wclk)
        ,.rst_n       (wrst_n)
        ,.wr_en       (wr_en)
        ,.wr_data     (wr_data)
        ,.rd_ptr_gray (rd_ptr_gray)
        ,.pg_ready    (pg_ready)
        ,.full        (full)
        ,.wr_ptr_gray (wr_ptr_gray)
        ,.we          (we)
        ,.waddr       (waddr)
        ,.wdata       (wdata)
    );

    rf_fifo_rd #(.SYNC_STAGES(SYNC_STAGES)) i_rf_fifo_rd (
         .rclk        (rclk)
        ,.rst_n       (rrst_n)
        ,.rd_en       (rd_en)
        ,.wr_ptr_gray (wr_ptr_gray)
        ,.rdata       (rdata)
        ,.empty       (empty)
        ,.rd_ptr_gray (rd_ptr_gray)
        ,.re          (re)
        ,.raddr       (raddr)
        ,.rd_valid    (rd_valid)
        ,.rd_data     (rd_data)
    );

    //----------------------------------------------------------------------
    // Power sequencing and storage

    rf_pg_ctrl i_rf_pg_ctrl (
         .rclk             (rclk)
        ,.rst_n            (rrst_n)
        ,.sleep_req        (sleep_req)
        ,.empty            (empty)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pg_ready         (pg_ready)
    );

    // The wrapper brings its own reset onto rclk
    rf_pg_4x27 i_rf_pg_4x27 (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.ip_reset_b       (arst_n)
    );

endmodule : rf_fifo_top

/* design/rf_fifo_rd.sv */
//--------------------------------------------------------------------------
// FIFO read side in the rclk domain
// Gray read pointer, synchronized write pointer and empty flag
// Read strobe to the register file and the valid pulse for its data
//--------------------------------------------------------------------------

module rf_fifo_rd
    import rf_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
     input  logic     rclk
    ,input  logic     rst_n
    ,input  logic     rd_en
    ,input  rf_ptr_t  wr_ptr_gray
    ,input  rf_data_t rdata
    ,output logic     empty
    ,output rf_ptr_t  rd_ptr_gray
    ,output logic     re
    ,output rf_addr_t raddr
    ,output logic     rd_valid
    ,output rf_data_t rd_data
);

    localparam int AW = $clog2(RF_DEPTH);

    // Write pointer crossing from wclk
    rf_ptr_t [SYNC_STAGES-1:0] wr_ptr_sync;
    rf_ptr_t                   wr_ptr_r;

    // Binary read pointer and its next values
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    rf_ptr_t     rd_gray_next;
    logic        empty_next;
    logic        accept;

    //----------------------------------------------------------------------
    // Clock domain crossing

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_sync <= '0;
        end else begin
            wr_ptr_sync <= {wr_ptr_sync[SYNC_STAGES-2:0], wr_ptr_gray};
        end
    end

    assign wr_ptr_r = wr_ptr_sync[SYNC_STAGES-1];

    //----------------------------------------------------------------------
    // Pointer update and empty

    // A read request on an empty FIFO is ignored
    assign accept       = rd_en && !empty;
    assign rd_bin_next  = rd_bin + (AW+1)'(accept);
    assign rd_gray_next = rf_ptr_t'(rd_bin_next ^ (rd_bin_next >> 1));

    // Empty once the read pointer catches up with the synced write pointer
    assign empty_next = (rd_gray_next == wr_ptr_r);

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin      <= '0;
            rd_ptr_gray <= '0;
            empty       <= 1'b1;
            rd_valid    <= 1'b0;
        end else begin
            rd_bin      <= rd_bin_next;
            rd_ptr_gray <= rd_gray_next;
            empty       <= empty_next;
            // Array data arrives one cycle after the strobe
            rd_valid    <= accept;
        end
    end

    assign re    = accept;
    assign raddr = rd_bin[AW-1:0];

    // Data lines up with rd_valid straight from the array register
    assign rd_data = rdata;

endmodule : rf_fifo_rd

/* design/rf_fifo_wr.sv */
//--------------------------------------------------------------------------
// FIFO write side in the wclk domain
// Gray write pointer, synchronized read pointer and power ready
// Full flag and write strobe generation for the register file
//--------------------------------------------------------------------------

module rf_fifo_wr
    import rf_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
     input  logic     wclk
    ,input  logic     rst_n
    ,input  logic     wr_en
    ,input  rf_data_t wr_data
    ,input  rf_ptr_t  rd_ptr_gray
    ,input  logic     pg_ready
    ,output logic     full
    ,output rf_ptr_t  wr_ptr_gray
    ,output logic     we
    ,output rf_addr_t waddr
    ,output rf_data_t wdata
);

    localparam int AW = $clog2(RF_DEPTH);

    // Read pointer and ready flag crossing from rclk
    rf_ptr_t [SYNC_STAGES-1:0] rd_ptr_sync;
    logic    [SYNC_STAGES-1:0] ready_sync;
    rf_ptr_t                   rd_ptr_w;

    // Binary write pointer and its next values
    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    rf_ptr_t     wr_gray_next;
    logic        full_next;
    logic        accept;

    //----------------------------------------------------------------------
    // Clock domain crossing

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_sync <= '0;
            ready_sync  <= '0;
        end else begin
            rd_ptr_sync <= {rd_ptr_sync[SYNC_STAGES-2:0], rd_ptr_gray};
            ready_sync  <= {ready_sync[SYNC_STAGES-2:0], pg_ready};
        end
    end

    assign rd_ptr_w = rd_ptr_sync[SYNC_STAGES-1];

    //----------------------------------------------------------------------
    // Pointer update and full

    // Writes that arrive while full or not ready are simply dropped
    assign accept       = wr_en && !full && ready_sync[SYNC_STAGES-1];
    assign wr_bin_next  = wr_bin + (AW+1)'(accept);
    assign wr_gray_next = rf_ptr_t'(wr_bin_next ^ (wr_bin_next >> 1));

    // Full when the pointers differ only in the two top Gray bits
    assign full_next = (wr_gray_next == {~rd_ptr_w[AW:AW-1], rd_ptr_w[AW-2:0]});

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin      <= '0;
            wr_ptr_gray <= '0;
            full        <= 1'b0;
        end else begin
            wr_bin      <= wr_bin_next;
            wr_ptr_gray <= wr_gray_next;
            full        <= full_next;
        end
    end

    // The strobe goes to the array in the cycle the write is accepted
    assign we    = accept;
    assign waddr = wr_bin[AW-1:0];
    assign wdata = wr_data;

endmodule : rf_fifo_wr

/* design/rf_pg_ctrl.sv */
//--------------------------------------------------------------------------
// Power-gating sequencer in the rclk domain
// Powers the array up after reset and cycles it through sleep on request
// Isolation always covers the interval in which power is off
//--------------------------------------------------------------------------

module rf_pg_ctrl
    import rf_pkg::*;
(
     input  logic rclk
    ,input  logic rst_n
    ,input  logic sleep_req
    ,input  logic empty
    ,input  logic pwr_enable_b_out
    ,output logic pgcb_isol_en
    ,output logic pwr_enable_b
    ,output logic pg_ready
);

    pg_state_e state_q;
    pg_state_e state_d;

    //----------------------------------------------------------------------
    // Next state

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            // Stay down while sleep is still requested
            pg_off: begin
                if (!sleep_req) begin
                    state_d = pg_wake;
                end
            end
            // Power is being applied, wait for the array to confirm
            pg_wake: begin
                if (!pwr_enable_b_out) begin
                    state_d = pg_on;
                end
            end
            // Sleep only with nothing left in the FIFO
            pg_on: begin
                if (sleep_req && empty) begin
                    state_d = pg_isolate;
                end
            end
            // One cycle of isolation before power is removed
            pg_isolate: begin
                state_d = pg_sleep_wait;
            end
            // Power is being removed, wait for the acknowledge
            pg_sleep_wait: begin
                if (pwr_enable_b_out) begin
                    state_d = pg_off;
                end
            end
            default: begin
                state_d = pg_off;
            end
        endcase
    end

    //----------------------------------------------------------------------
    // State and registered outputs

    // Outputs are decoded from the next state so that they change on the
    // same edge as the state and never glitch toward the array
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= pg_off;
            pgcb_isol_en <= 1'b1;
            pwr_enable_b <= 1'b1;
            pg_ready     <= 1'b0;
        end else begin
            state_q      <= state_d;
            // Isolated in every state but pg_on
            pgcb_isol_en <= (state_d != pg_on);
            // Power is off only where isolation is already up
            pwr_enable_b <= (state_d == pg_off) || (state_d == pg_sleep_wait);
            pg_ready     <= (state_d == pg_on);
        end
    end

endmodule : rf_pg_ctrl

/* design/rf_pg_4x27.sv */
//--------------------------------------------------------------------------
// Power-gated 4x27 register file wrapper
// Pads the data word to the 28 bit array width and strips it on read
// Synchronizes the IP reset onto rclk and routes the power controls
//--------------------------------------------------------------------------

module rf_pg_4x27
    import rf_pkg::*;
(
     input  logic     wclk
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    ,input  logic     rclk
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_data_t rdata

    // Power interface
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in
    ,output logic     pwr_enable_b_out

    ,input  logic     ip_reset_b
);

    // IP reset after release onto rclk
    logic     ip_reset_b_sync;

    // Full-width words on both sides of the array
    rf_word_t wdata_word;
    rf_word_t rdata_word;

    // The array reset is released on the read clock
    rf_reset_sync i_ip_reset_b_sync (
         .clk        (rclk)
        ,.arst_n     (ip_reset_b)
        ,.rst_n_sync (ip_reset_b_sync)
    );

    // Spare top bit is always written as zero
    assign wdata_word = {1'b0, wdata};

    //----------------------------------------------------------------------
    // Storage array

    rf_array_4x28 i_rf (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata_word)
        ,.rclk             (rclk)
        ,.rst_n            (ip_reset_b_sync)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata_word)
        ,.isol_en          (pgcb_isol_en)
        ,.pwr_enable_b     (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Drop the spare bit on the way out
    assign rdata = rdata_word[$bits(rf_data_t)-1:0];

endmodule : rf_pg_4x27

/* design/rf_array_4x28.sv */
//--------------------------------------------------------------------------
// Behavioral two-clock 4x28 storage array
// Write port on wclk, registered read port on rclk
// Models content loss at power-down, output isolation clamp and
// the delayed power enable acknowledge
//--------------------------------------------------------------------------

module rf_array_4x28
    import rf_pkg::*;
(
     input  logic     wclk
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_word_t wdata

    ,input  logic     rclk
    ,input  logic     rst_n
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_word_t rdata

    ,input  logic     isol_en
    ,input  logic     pwr_enable_b
    ,output logic     pwr_enable_b_out
);

    // Storage cells
    rf_word_t mem [RF_DEPTH];

    // Read data register ahead of the isolation clamp
    rf_word_t rdata_q;

    // Acknowledge delay line, the last stage drives pwr_enable_b_out
    logic [PG_ACK_DELAY-1:0] ack_sr;

    //----------------------------------------------------------------------
    // Write port

    // A powered-down array holds nothing, so every cell is wiped while
    // the power enable is high and writes have no effect
    always_ff @(posedge wclk) begin
        if (pwr_enable_b) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //----------------------------------------------------------------------
    // Read port

    // Data shows up one rclk cycle after re
    always_ff @(posedge rclk) begin
        if (re) begin
            rdata_q <= mem[raddr];
        end
    end

    // Isolation forces the outputs to a known zero while the array
    // may be unpowered
    assign rdata = isol_en ? '0 : rdata_q;

    //----------------------------------------------------------------------
    // Power acknowledge

    // The array comes out of reset as if powered off
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            ack_sr <= '1;
        end else begin
            ack_sr <= {ack_sr[PG_ACK_DELAY-2:0], pwr_enable_b};
        end
    end

    assign pwr_enable_b_out = ack_sr[PG_ACK_DELAY-1];

endmodule : rf_array_4x28

/* design/rf_reset_sync.sv */
//--------------------------------------------------------------------------
// Reset synchronizer
// Asserts asynchronously and releases on the rising edge of clk
//--------------------------------------------------------------------------

module rf_reset_sync (
     input  logic clk
    ,input  logic arst_n
    ,output logic rst_n_sync
);

    // First stage may go metastable when arst_n releases close to clk
    logic meta;

    // Both flops clear at once on reset assertion
    // The release walks through the two stages so that the output
    // deasserts cleanly on a clk edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta       <= 1'b0;
            rst_n_sync <= 1'b0;
        end else begin
            meta       <= 1'b1;
            rst_n_sync <= meta;
        end
    end

endmodule : rf_reset_sync

/* design/rf_pkg.sv */
//--------------------------------------------------------------------------
// Shared types and constants for the dual-clock register file FIFO
// Data, stored word, address and Gray pointer types
// Power sequencer state encoding and timing constants
//--------------------------------------------------------------------------

package rf_pkg;

    // Number of entries in the register file
    localparam int RF_DEPTH = 4;

    // Cycles of rclk between a change on the power enable and its acknowledge
    localparam int PG_ACK_DELAY = 2;

    // One FIFO data word as seen by the user
    typedef logic [27-1:0] rf_data_t;

    // One stored word in the array, the top bit is a spare held at zero
    typedef logic [28-1:0] rf_word_t;

    // Register file entry address
    typedef logic [2-1:0] rf_addr_t;

    // Gray coded FIFO pointer with one wrap bit above the address
    typedef logic [3-1:0] rf_ptr_t;

    //----------------------------------------------------------------------
    // Power sequencer states

    typedef enum logic [2:0] {
         pg_off
        ,pg_wake
        ,pg_on
        ,pg_isolate
        ,pg_sleep_wait
    } pg_state_e;

endpackage : rf_pkg
